// ==== hw/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Byte address width on both sides
`define MEM_ADDR_W 32

// One bus beat, one processor word
`define MEM_WORD_W 32

// Bus beats per cache line
`define MEM_LINE_WORDS 4

// Whole line as moved between cache and buffer
`define MEM_LINE_W 128

// Direct mapped, so one line per index
`define MEM_CACHE_LINES 16

`endif

// ==== hw/cache_pkg.sv ====
`include "mem_consts.svh"

package cache_pkg;

	// Processor word access
	typedef struct packed {
		logic                   write;  // Store when set
		logic [`MEM_ADDR_W-1:0] addr;   // Word aligned byte address
		logic [`MEM_WORD_W-1:0] wdata;  // Store data
	} cpu_req_t;

	// Response word
	typedef struct packed {
		logic [`MEM_WORD_W-1:0] rdata;  // Load data, don't care on stores
	} cpu_resp_t;

	//////////////////////////////////////////////////
	// Line transfer between cache and mem_buffer
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                   write;  // Writeback when set, fill otherwise
		logic [`MEM_ADDR_W-1:0] addr;   // Line base, low bits zero
		logic [`MEM_LINE_W-1:0] wdata;  // Line to write back
	} line_req_t;

	// Line read data comes back as a plain vector
	// Word 0 sits in the low bits

endpackage

// ==== hw/bus_pkg.sv ====
`include "mem_consts.svh"

package bus_pkg;

	// System bus request, held as a level
	typedef struct packed {
		logic                   rd;     // Read beat pending
		logic                   wr;     // Write beat pending
		logic [`MEM_ADDR_W-1:0] addr;   // Word address of current beat
		logic [`MEM_WORD_W-1:0] wdata;  // Write word of current beat
	} bus_req_t;

	// Beat within a line
	typedef logic [$clog2(`MEM_LINE_WORDS)-1:0] beat_t;

	// Bus side handshake
	// A beat completes on each edge with bus_ready high
	// rdata sampled on that same edge

endpackage

// ==== hw/mem_buffer.sv ====
`include "mem_consts.svh"

module mem_buffer (
	input  logic                   clk,
	input  logic                   reset,

	// Line side
	input  logic                   line_start,  // One cycle strobe
	input  cache_pkg::line_req_t   line_req,
	output logic                   line_done,   // One cycle strobe
	output logic [`MEM_LINE_W-1:0] line_rdata,

	// System bus
	output bus_pkg::bus_req_t      bus_req,
	input  logic [`MEM_WORD_W-1:0] bus_rdata,
	input  logic                   bus_ready
);

	localparam int WORD_W = `MEM_WORD_W;
	localparam int ADDR_W = `MEM_ADDR_W;
	localparam int BYTE_W = $clog2(`MEM_WORD_W / 8);  // Byte offset in a word
	localparam int OFF_W  = $clog2(`MEM_LINE_W / 8);  // Byte offset in a line
	localparam bus_pkg::beat_t LAST_BEAT = bus_pkg::beat_t'(`MEM_LINE_WORDS - 1);

	logic                 active;     // Transfer in progress
	bus_pkg::beat_t       beat;       // Current beat
	cache_pkg::line_req_t req_q;      // Held line request
	logic                 beat_done;  // Beat completes this edge

	assign beat_done = active && bus_ready;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			beat      <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= 1'b0;  // Strobe by default
			if (line_start) begin
				active <= 1'b1;   // rd/wr rise next cycle
				beat   <= '0;
			end else if (beat_done) begin
				beat <= beat + 1'b1;
				if (beat == LAST_BEAT) begin
					// Drop request and signal cache after the last word
					active    <= 1'b0;
					line_done <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Line data
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (line_start)
			req_q <= line_req;  // Address and writeback data
		// Read words land in their beat slot
		if (beat_done && !req_q.write)
			line_rdata[beat*WORD_W +: WORD_W] <= bus_rdata;
	end

	// Bus request straight from held state
	always_comb begin
		bus_req.rd    = active && !req_q.write;
		bus_req.wr    = active && req_q.write;
		bus_req.addr  = {req_q.addr[ADDR_W-1:OFF_W], beat, {BYTE_W{1'b0}}};  // Base + 4*beat
		bus_req.wdata = req_q.wdata[beat*WORD_W +: WORD_W];  // Beat 0 is bits 31:0
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Stalled beat holds the whole request
	a_stall_hold: assert property (@(posedge clk) disable iff (reset)
		active && !bus_ready |=> $stable(bus_req))
		else $error("mem_buffer: bus_req changed during stall");

	// Cache waits for line_done before next line
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		line_start |-> !active)
		else $error("mem_buffer: line_start during transfer");

endmodule

// ==== hw/line_cache.sv ====
`include "mem_consts.svh"

module line_cache (
	input  logic                   clk,
	input  logic                   reset,

	// Processor side
	input  logic                   cpu_valid,   // One cycle request strobe
	input  cache_pkg::cpu_req_t    cpu_req,
	output logic                   resp_valid,  // One cycle response strobe
	output cache_pkg::cpu_resp_t   cpu_resp,

	// Line side toward mem_buffer
	output logic                   line_start,
	output cache_pkg::line_req_t   line_req,
	input  logic                   line_done,
	input  logic [`MEM_LINE_W-1:0] line_rdata
);

	localparam int LINES  = `MEM_CACHE_LINES;
	localparam int WORD_W = `MEM_WORD_W;
	localparam int ADDR_W = `MEM_ADDR_W;
	localparam int IDX_W  = $clog2(`MEM_CACHE_LINES);   // Index bits 7:4
	localparam int OFF_W  = $clog2(`MEM_LINE_W / 8);    // Line offset bits 3:0
	localparam int BYTE_W = $clog2(`MEM_WORD_W / 8);    // Byte in word
	localparam int SEL_W  = $clog2(`MEM_LINE_WORDS);    // Word select bits 3:2
	localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;     // Tag bits 31:8

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRITEBACK,  // Dirty victim going out
		S_FILL,       // Waiting for new line
		S_RESPOND     // Response cycle, store merge
	} state_t;

	state_t state;

	// Storage arrays
	logic [TAG_W-1:0]       tag_mem  [LINES];
	logic [`MEM_LINE_W-1:0] data_mem [LINES];
	logic [LINES-1:0]       valid;
	logic [LINES-1:0]       dirty;

	cache_pkg::cpu_req_t req_q;  // Request being served

	logic [IDX_W-1:0] cpu_idx;
	logic [TAG_W-1:0] cpu_tag;
	logic [IDX_W-1:0] req_idx;
	logic [TAG_W-1:0] req_tag;
	logic [SEL_W-1:0] req_sel;
	logic             hit;
	logic             evict;
	logic             accept;
	logic             wb_done;
	logic             fill_done;
	logic             store_now;

	// Line base of a byte address
	function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
		return {addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
	endfunction

	// Lookup on the incoming address
	assign cpu_idx = cpu_req.addr[OFF_W +: IDX_W];
	assign cpu_tag = cpu_req.addr[ADDR_W-1 -: TAG_W];
	assign hit     = valid[cpu_idx] && (tag_mem[cpu_idx] == cpu_tag);
	assign evict   = valid[cpu_idx] && dirty[cpu_idx];  // Only matters on a miss

	// Fields of the held request
	assign req_idx = req_q.addr[OFF_W +: IDX_W];
	assign req_tag = req_q.addr[ADDR_W-1 -: TAG_W];
	assign req_sel = req_q.addr[BYTE_W +: SEL_W];

	assign accept    = (state == S_IDLE) && cpu_valid;
	assign wb_done   = (state == S_WRITEBACK) && line_done;
	assign fill_done = (state == S_FILL) && line_done;
	assign store_now = (state == S_RESPOND) && req_q.write;

	//////////////////////////////////////////////////
	// Miss FSM and valid/dirty bits
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= S_IDLE;
			line_start <= 1'b0;
			valid      <= '0;
			dirty      <= '0;
		end else begin
			line_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cpu_valid) begin
						if (hit) begin
							state <= S_RESPOND;  // Answer next cycle
						end else begin
							line_start <= 1'b1;
							state      <= evict ? S_WRITEBACK : S_FILL;
						end
					end
				end
				S_WRITEBACK: begin
					if (line_done) begin
						line_start <= 1'b1;  // Fill right after writeback
						state      <= S_FILL;
					end
				end
				S_FILL: begin
					if (line_done) begin
						valid[req_idx] <= 1'b1;
						dirty[req_idx] <= 1'b0;  // Fresh copy of memory
						state          <= S_RESPOND;
					end
				end
				default: begin  // S_RESPOND
					if (req_q.write)
						dirty[req_idx] <= 1'b1;
					state <= S_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Request, line request and arrays
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= cpu_req;
			if (!hit && evict)  // Victim line from its own tag
				line_req <= '{write: 1'b1,
					addr: {tag_mem[cpu_idx], cpu_idx, {OFF_W{1'b0}}},
					wdata: data_mem[cpu_idx]};
			else if (!hit)
				line_req <= '{write: 1'b0, addr: line_base(cpu_req.addr), wdata: '0};
		end
		if (wb_done)
			line_req <= '{write: 1'b0, addr: line_base(req_q.addr), wdata: '0};
		if (fill_done) begin
			tag_mem[req_idx]  <= req_tag;
			data_mem[req_idx] <= line_rdata;
		end
		// Store merges one word, hit or after fill
		if (store_now)
			data_mem[req_idx][req_sel*WORD_W +: WORD_W] <= req_q.wdata;
	end

	assign resp_valid     = (state == S_RESPOND);
	assign cpu_resp.rdata = data_mem[req_idx][req_sel*WORD_W +: WORD_W];  // Line already in place

	// Processor waits for the response before the next request
	a_req_in_idle: assert property (@(posedge clk) disable iff (reset)
		cpu_valid |-> state == S_IDLE)
		else $error("line_cache: cpu_valid while busy");

endmodule

// ==== hw/dmem_subsys.sv ====
`include "mem_consts.svh"

module dmem_subsys (
	input  logic                   clk,
	input  logic                   reset,

	// Processor side
	input  logic                   cpu_valid,
	input  cache_pkg::cpu_req_t    cpu_req,
	output logic                   resp_valid,
	output cache_pkg::cpu_resp_t   cpu_resp,

	// System bus
	output bus_pkg::bus_req_t      bus_req,
	input  logic [`MEM_WORD_W-1:0] bus_rdata,
	input  logic                   bus_ready
);

	// Cache to buffer line link
	logic                   line_start;
	logic                   line_done;
	cache_pkg::line_req_t   line_req;
	logic [`MEM_LINE_W-1:0] line_rdata;

	line_cache i_line_cache (
		.clk        (clk),
		.reset      (reset),
		.cpu_valid  (cpu_valid),
		.cpu_req    (cpu_req),
		.resp_valid (resp_valid),
		.cpu_resp   (cpu_resp),
		.line_start (line_start),
		.line_req   (line_req),
		.line_done  (line_done),
		.line_rdata (line_rdata)
	);

	mem_buffer i_mem_buffer (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.line_req   (line_req),
		.line_done  (line_done),
		.line_rdata (line_rdata),
		.bus_req    (bus_req),
		.bus_rdata  (bus_rdata),
		.bus_ready  (bus_ready)
	);

endmodule

// ==== sim/bus_mem_model.sv ====
`include "mem_consts.svh"

module bus_mem_model (
	input  logic                   clk,

	// System bus slave side
	input  bus_pkg::bus_req_t      bus_req,
	output logic [`MEM_WORD_W-1:0] bus_rdata,
	output logic                   bus_ready
);

	// Sparse backing store, only written words live here
	bit [`MEM_WORD_W-1:0] mem [bit [`MEM_ADDR_W-1:0]];

	integer seed = 32'hc7a9_c546;  // Stall pattern
	logic   ready_next;

	// Untouched words follow the fill rule
	function automatic logic [`MEM_WORD_W-1:0] read_word(input logic [`MEM_ADDR_W-1:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 32'h5a5a_0000;
	endfunction

	initial begin
		bus_ready = 1'b0;
		bus_rdata = '0;
	end

	//////////////////////////////////////////////////
	// Slave response, decided on the falling edge
	//////////////////////////////////////////////////

	// bus_req only moves on the rising edge, so it is the beat
	// that the next rising edge will see
	always @(negedge clk) begin
		ready_next = ($random(seed) & 3) != 0;  // Stall about one cycle in four
		if (ready_next && bus_req.wr)
			mem[bus_req.addr] = bus_req.wdata;  // Beat completes at next edge
		bus_rdata = read_word(bus_req.addr);  // Word for current beat
		bus_ready = ready_next;
	end

endmodule

// ==== sim/tb_dmem_subsys.sv ====
`include "mem_consts.svh"

module tb_dmem_subsys;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   cpu_valid;
	cache_pkg::cpu_req_t    cpu_req;
	logic                   resp_valid;
	cache_pkg::cpu_resp_t   cpu_resp;
	bus_pkg::bus_req_t      bus_req;
	logic [`MEM_WORD_W-1:0] bus_rdata;
	logic                   bus_ready;

	integer seed = 32'hc7a9_c546;

	bit [`MEM_WORD_W-1:0] ref_mem [bit [`MEM_ADDR_W-1:0]];  // Reference memory
	bus_pkg::bus_req_t    exp_beats [$];                    // Beats still owed on the bus

	// Shadow of the cache tags
	bit        sh_valid [`MEM_CACHE_LINES];
	bit        sh_dirty [`MEM_CACHE_LINES];
	bit [23:0] sh_tag   [`MEM_CACHE_LINES];

	dmem_subsys i_dmem_subsys (
		.clk        (clk),
		.reset      (reset),
		.cpu_valid  (cpu_valid),
		.cpu_req    (cpu_req),
		.resp_valid (resp_valid),
		.cpu_resp   (cpu_resp),
		.bus_req    (bus_req),
		.bus_rdata  (bus_rdata),
		.bus_ready  (bus_ready)
	);

	bus_mem_model i_bus_mem_model (
		.clk       (clk),
		.bus_req   (bus_req),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready)
	);

	initial forever #20 clk = ~clk;

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		stop_run();
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic bit [31:0] ref_read(input bit [31:0] addr);
		if (ref_mem.exists(addr))
			return ref_mem[addr];
		return addr ^ 32'h5a5a_0000;  // Power-up content
	endfunction

	// Four tags per index, tag lands in bits 31:8
	function automatic logic [31:0] make_addr(input logic [1:0] tag_sel, input logic [3:0] idx,
		input logic [1:0] sel);
		return {4'h1, 18'h0, tag_sel, idx, sel, 2'b00};
	endfunction

	// One processor access, predicted bus traffic queued up front
	task automatic do_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
		logic [3:0]        idx;
		logic [23:0]       tag;
		logic [31:0]       victim;
		logic [31:0]       exp_rdata;
		logic              hit_exp;
		bus_pkg::bus_req_t b;
		int                cycles;
		idx       = addr[7:4];
		tag       = addr[31:8];
		hit_exp   = sh_valid[idx] && (sh_tag[idx] == tag);
		exp_rdata = ref_read(addr);
		if (!hit_exp) begin
			if (sh_valid[idx] && sh_dirty[idx]) begin
				victim = {sh_tag[idx], idx, 4'h0};  // Writeback of old line first
				for (int i = 0; i < `MEM_LINE_WORDS; i++) begin
					b = '{rd: 1'b0, wr: 1'b1, addr: victim + 4 * i, wdata: ref_read(victim + 4 * i)};
					exp_beats.push_back(b);
				end
			end
			for (int i = 0; i < `MEM_LINE_WORDS; i++) begin
				b = '{rd: 1'b1, wr: 1'b0, addr: {tag, idx, 4'h0} + 4 * i, wdata: '0};
				exp_beats.push_back(b);
			end
			sh_valid[idx] = 1'b1;
			sh_tag[idx]   = tag;
			sh_dirty[idx] = 1'b0;
		end
		if (wr) begin
			ref_mem[addr] = wdata;
			sh_dirty[idx] = 1'b1;
		end
		cpu_valid = 1'b1;
		cpu_req   = '{write: wr, addr: addr, wdata: wdata};
		@(negedge clk);
		cpu_valid = 1'b0;  // Single cycle strobe
		cycles    = 1;
		while (!resp_valid && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!resp_valid)
			abort_run("no resp_valid within 200 cycles of cpu_valid");
		if (hit_exp)
			compare_value("hit latency", 1, cycles);
		if (!wr)
			compare_value("cpu_resp.rdata", exp_rdata, cpu_resp.rdata);
		compare_value("beats left", 0, exp_beats.size());
	endtask

	// Quiet cycles between accesses, no stray response
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			compare_value("resp_valid", 0, resp_valid);
		end
	endtask

	//////////////////////////////////////////////////
	// Bus monitor
	//////////////////////////////////////////////////

	// DUT outputs still hold the pre-edge beat here
	always @(posedge clk) begin : beat_monitor
		bus_pkg::bus_req_t b;
		if (!reset) begin
			compare_value("bus_req.rd & bus_req.wr", 0, bus_req.rd & bus_req.wr);
			if (bus_req.rd || bus_req.wr) begin
				if (exp_beats.size() == 0)
					abort_run("bus request seen while no line transfer was expected");
				else if (bus_ready) begin
					b = exp_beats.pop_front();
					compare_value("bus_req.rd", b.rd, bus_req.rd);
					compare_value("bus_req.wr", b.wr, bus_req.wr);
					compare_value("bus_req.addr", b.addr, bus_req.addr);
					if (b.wr)
						compare_value("bus_req.wdata", b.wdata, bus_req.wdata);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [1:0] tag_sel;
		logic [3:0] idx;
		logic [1:0] sel;
		reset     = 1'b1;
		cpu_valid = 1'b0;
		cpu_req   = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		idle_cycles(4);  // Nothing moves before first request
		tag_sel = $random(seed);
		idx     = $random(seed);
		sel     = $random(seed);
		do_access(1'b0, make_addr(tag_sel, idx, sel), '0);  // Cold load, fill only
		for (int n = 0; n < 400; n++) begin
			idle_cycles(1 + ($unsigned($random(seed)) % 3));
			if (($random(seed) & 3) != 0) begin  // Else stay on same line
				tag_sel = $random(seed);
				idx     = $random(seed);
			end
			sel = $random(seed);
			do_access($random(seed) & 1, make_addr(tag_sel, idx, sel), $random(seed));
		end
		idle_cycles(2);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+hw
hw/cache_pkg.sv
hw/bus_pkg.sv
hw/mem_buffer.sv
hw/line_cache.sv
hw/dmem_subsys.sv
sim/bus_mem_model.sv
sim/tb_dmem_subsys.sv
